// File: hdl/ppu_defines.svh
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// the posit format uses 8-bit words with no exponent field.
`define PPU_N 8
`define PPU_ES 0

// number of independent lanes in one vector command.
`define PPU_LANES 4

// signed total exponent, wide enough for a normalized product of two posits.
`define PPU_TE_BITS 6

// decoded fraction width, the hidden bit included.
`define PPU_FRAC_BITS 6

// product fraction bits kept below the leading one.
`define PPU_FRAC_FULL_BITS 10

`endif

// File: hdl/ppu_pkg.sv
`include "ppu_defines.svh"

package ppu_pkg;

  typedef logic [`PPU_N-1:0] posit_t;
  typedef posit_t [`PPU_LANES-1:0] posit_vec_t;
  typedef logic signed [`PPU_TE_BITS-1:0] exponent_t;

  // the two special encodings of a posit.
  localparam posit_t POSIT_ZERO = '0;
  localparam posit_t POSIT_NAR = {1'b1, {(`PPU_N-1){1'b0}}};

  // total exponent of maxpos; minpos sits at its negative.
  localparam int MAX_TE = (`PPU_N - 2) << `PPU_ES;

  typedef enum logic {
    OP_MUL = 1'b0,
    OP_SQR = 1'b1
  } ppu_op_e;

  typedef struct packed {
    logic                      sign;
    exponent_t                 total_exp;
    logic [`PPU_FRAC_BITS-1:0] frac;
    logic                      is_zero;
    logic                      is_nar;
  } fir_t;

  // frac_full holds only the bits below the leading one.
  typedef struct packed {
    logic                           sign;
    exponent_t                      total_exp;
    logic [`PPU_FRAC_FULL_BITS-1:0] frac_full;
  } long_fir_t;

  typedef struct packed {
    long_fir_t long_fir;
    logic      frac_truncated;
    logic      is_zero;
    logic      is_nar;
  } ops_out_meta_t;

  typedef struct packed {
    posit_t a;
    posit_t b;
  } lane_operands_t;

endpackage

// File: hdl/posit_decode.sv
`timescale 1ns/1ns
`include "ppu_defines.svh"

module posit_decode
  import ppu_pkg::*;
(
  input  posit_t posit_i,
  output fir_t   fir_o
);

  localparam int BODY_BITS = `PPU_N - 1;
  localparam int RUN_BITS = $clog2(`PPU_N);
  localparam int SHIFT_BITS = RUN_BITS + 1;

  posit_t                abs_val;
  logic [BODY_BITS-1:0]  body;
  logic [BODY_BITS-1:0]  tail;
  logic [RUN_BITS-1:0]   run_len;
  logic                  running;
  exponent_t             run_exp;

  // the negative code 0x80 maps onto itself and is caught by the NaR flag.
  assign abs_val = posit_i[`PPU_N-1] ? -posit_i : posit_i;
  assign body = abs_val[BODY_BITS-1:0];

  // count the regime run, which starts right below the sign bit.
  always_comb begin
    run_len = RUN_BITS'(1);
    running = 1'b1;
    for (int i = BODY_BITS - 2; i >= 0; i--) begin
      if (running && (body[i] == body[BODY_BITS-1])) begin
        run_len = run_len + 1'b1;
      end else begin
        running = 1'b0;
      end
    end
  end

  // with no exponent field the total exponent is the regime value k.
  assign run_exp = exponent_t'(run_len);

  // dropping the run and its terminator leaves the fraction left-aligned.
  assign tail = body << (SHIFT_BITS'(run_len) + 1'b1);

  assign fir_o.sign = posit_i[`PPU_N-1];
  assign fir_o.total_exp = body[BODY_BITS-1] ? run_exp - exponent_t'(1) : -run_exp;
  assign fir_o.frac = {1'b1, tail[BODY_BITS-1 -: `PPU_FRAC_BITS-1]};
  assign fir_o.is_zero = (posit_i == POSIT_ZERO);
  assign fir_o.is_nar = (posit_i == POSIT_NAR);

endmodule

// File: hdl/fir_mul.sv
`timescale 1ns/1ns
`include "ppu_defines.svh"

module fir_mul
  import ppu_pkg::*;
(
  input  fir_t          a_i,
  input  fir_t          b_i,
  output ops_out_meta_t ops_result_o
);

  localparam int PROD_BITS = 2 * `PPU_FRAC_BITS;
  localparam int FULL_BITS = `PPU_FRAC_FULL_BITS;

  logic [PROD_BITS-1:0] frac_prod;
  exponent_t            exp_sum;
  long_fir_t            prod_fir;
  logic                 truncated;

  // both fractions lie in [1, 2), so the product lies in [1, 4).
  assign frac_prod = a_i.frac * b_i.frac;
  assign exp_sum = a_i.total_exp + b_i.total_exp;

  always_comb begin
    prod_fir.sign = a_i.sign ^ b_i.sign;
    if (frac_prod[PROD_BITS-1]) begin
      // a product of 2 or more has its leading one one place higher.
      prod_fir.total_exp = exp_sum + exponent_t'(1);
      prod_fir.frac_full = frac_prod[PROD_BITS-2 -: FULL_BITS];
      truncated = |frac_prod[PROD_BITS-2-FULL_BITS:0];
    end else begin
      // every bit below the leading one fits into frac_full here.
      prod_fir.total_exp = exp_sum;
      prod_fir.frac_full = frac_prod[PROD_BITS-3 -: FULL_BITS];
      truncated = 1'b0;
    end
  end

  assign ops_result_o.long_fir = prod_fir;
  assign ops_result_o.frac_truncated = truncated;
  assign ops_result_o.is_zero = a_i.is_zero | b_i.is_zero;
  assign ops_result_o.is_nar = a_i.is_nar | b_i.is_nar;

endmodule

// File: hdl/fir_to_posit.sv
`timescale 1ns/1ns
`include "ppu_defines.svh"

module fir_to_posit
  import ppu_pkg::*;
(
  input  ops_out_meta_t ops_result_i,
  output posit_t        posit_o
);

  localparam int BODY_BITS = `PPU_N - 1;
  localparam int FULL_BITS = `PPU_FRAC_FULL_BITS;
  // two seed bits, the fraction, and room for the longest regime shift.
  localparam int EXT_BITS = 2 + FULL_BITS + MAX_TE;
  localparam int SHIFT_BITS = $clog2(MAX_TE + 1);
  localparam logic [BODY_BITS-1:0] MAG_MAX = '1;
  localparam logic [BODY_BITS-1:0] MAG_MIN = BODY_BITS'(1);

  long_fir_t                   fir;
  logic                        te_nonneg;
  logic                        te_above;
  logic                        te_below;
  logic [SHIFT_BITS-1:0]       run_shift;
  logic signed [EXT_BITS-1:0]  ext_init;
  logic signed [EXT_BITS-1:0]  ext;
  logic [BODY_BITS-1:0]        mag;
  logic                        round_bit;
  logic                        sticky_bit;
  logic                        round_up;
  logic [BODY_BITS-1:0]        mag_rounded;
  logic [BODY_BITS-1:0]        mag_sat;
  posit_t                      posit_signed;

  assign fir = ops_result_i.long_fir;

  assign te_nonneg = ~fir.total_exp[`PPU_TE_BITS-1];
  assign te_above = fir.total_exp > exponent_t'(MAX_TE);
  assign te_below = fir.total_exp < -exponent_t'(MAX_TE);

  // a regime of k >= 0 is k+1 ones then a zero, k < 0 is -k zeros then a one.
  // the seed holds the first run bit and the terminator, and an arithmetic
  // shift stretches the run to its full length. for negative k the shift
  // is -k-1, which is the bitwise inverse of k.
  assign run_shift = te_nonneg ? fir.total_exp[SHIFT_BITS-1:0] :
                                 ~fir.total_exp[SHIFT_BITS-1:0];
  assign ext_init = {te_nonneg, ~te_nonneg, fir.frac_full, {MAX_TE{1'b0}}};
  assign ext = ext_init >>> run_shift;

  // the top bits form the unsigned magnitude and the rest feed the rounding.
  assign mag = ext[EXT_BITS-1 -: BODY_BITS];
  assign round_bit = ext[EXT_BITS-1-BODY_BITS];
  assign sticky_bit = (|ext[EXT_BITS-2-BODY_BITS:0]) | ops_result_i.frac_truncated;

  // nearest even on the bit pattern; maxpos is never incremented into NaR.
  assign round_up = round_bit & (sticky_bit | mag[0]) & (mag != MAG_MAX);
  assign mag_rounded = mag + BODY_BITS'(round_up);

  // out of range exponents clamp to maxpos or minpos and never to NaR or zero.
  always_comb begin
    if (te_above) begin
      mag_sat = MAG_MAX;
    end else if (te_below) begin
      mag_sat = MAG_MIN;
    end else begin
      mag_sat = mag_rounded;
    end
  end

  assign posit_signed = fir.sign ? -{1'b0, mag_sat} : {1'b0, mag_sat};

  // special operands win over the computed value, and NaR wins over zero.
  always_comb begin
    if (ops_result_i.is_nar) begin
      posit_o = POSIT_NAR;
    end else if (ops_result_i.is_zero) begin
      posit_o = POSIT_ZERO;
    end else begin
      posit_o = posit_signed;
    end
  end

endmodule

// File: hdl/ppu_lane.sv
`timescale 1ns/1ns

module ppu_lane
  import ppu_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           valid_i,
  input  lane_operands_t operands_i,
  output posit_t         result_o,
  output logic           valid_o
);

  fir_t          fir_a;
  fir_t          fir_b;
  ops_out_meta_t product;
  posit_t        result_d;

  posit_decode decode_a (
    .posit_i (operands_i.a),
    .fir_o   (fir_a)
  );

  posit_decode decode_b (
    .posit_i (operands_i.b),
    .fir_o   (fir_b)
  );

  fir_mul mul0 (
    .a_i          (fir_a),
    .b_i          (fir_b),
    .ops_result_o (product)
  );

  fir_to_posit encode0 (
    .ops_result_i (product),
    .posit_o      (result_d)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // the result register only loads for a live command.
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= result_d;
    end
  end

endmodule

// File: hdl/op_dispatch.sv
`timescale 1ns/1ns
`include "ppu_defines.svh"

module op_dispatch
  import ppu_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           valid_i,
  input  ppu_op_e        op_i,
  input  posit_vec_t     a_i,
  input  posit_vec_t     b_i,
  output lane_operands_t lane_ops_o [`PPU_LANES],
  output logic           valid_o
);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // a square reuses a as the second operand, so b_i is ignored then.
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      for (int i = 0; i < `PPU_LANES; i++) begin
        lane_ops_o[i].a <= a_i[i];
        lane_ops_o[i].b <= (op_i == OP_SQR) ? a_i[i] : b_i[i];
      end
    end
  end

endmodule

// File: hdl/result_collect.sv
`timescale 1ns/1ns
`include "ppu_defines.svh"

module result_collect
  import ppu_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  posit_vec_t lane_results_i,
  input  logic       lane_valid_i,
  output posit_vec_t result_o,
  output logic       valid_o,
  output logic       nar_o
);

  logic any_nar;

  always_comb begin
    any_nar = 1'b0;
    for (int i = 0; i < `PPU_LANES; i++) begin
      any_nar = any_nar | (lane_results_i[i] == POSIT_NAR);
    end
  end

  // nar_o is qualified by the valid so it only marks a live vector.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
      nar_o <= 1'b0;
    end else begin
      valid_o <= lane_valid_i;
      nar_o <= lane_valid_i & any_nar;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_valid_i) begin
      result_o <= lane_results_i;
    end
  end

endmodule

// File: hdl/ppu_vec_top.sv
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_vec_top
  import ppu_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       valid_i,
  input  ppu_op_e    op_i,
  input  posit_vec_t a_i,
  input  posit_vec_t b_i,
  output posit_vec_t result_o,
  output logic       valid_o,
  output logic       nar_o
);

  lane_operands_t        lane_ops [`PPU_LANES];
  logic                  dispatch_valid;
  posit_vec_t            lane_results;
  logic [`PPU_LANES-1:0] lane_valid;

  op_dispatch dispatch0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .lane_ops_o (lane_ops),
    .valid_o    (dispatch_valid)
  );

  for (genvar g = 0; g < `PPU_LANES; g++) begin : g_lane
    ppu_lane lane0 (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .valid_i    (dispatch_valid),
      .operands_i (lane_ops[g]),
      .result_o   (lane_results[g]),
      .valid_o    (lane_valid[g])
    );
  end

  // all lanes run in lockstep, so their valid bits always agree.
  result_collect collect0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .lane_results_i (lane_results),
    .lane_valid_i   (&lane_valid),
    .result_o       (result_o),
    .valid_o        (valid_o),
    .nar_o          (nar_o)
  );

endmodule

// File: tb/ppu_clock_gen.sv
`timescale 1ns/1ns

module ppu_clock_gen #(
  parameter int PERIOD = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// File: tb/ppu_vec_properties.sv
`timescale 1ns/1ns

module ppu_vec_properties (
  input logic clk_i,
  input logic reset_i,
  input logic valid_i,
  input logic valid_o,
  input logic nar_o
);

  int failures = 0;

  // one cycle into reset the output flags must already be cleared.
  a_reset_quiet: assert property (@(posedge clk_i) $past(reset_i) |-> !valid_o && !nar_o)
    else begin
      failures++;
      $error("valid_o or nar_o high during reset");
    end

  a_latency_fwd: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i |-> ##3 valid_o)
    else begin
      failures++;
      $error("valid_o missing 3 cycles after valid_i");
    end

  a_latency_back: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o |-> $past(valid_i, 3))
    else begin
      failures++;
      $error("valid_o without valid_i 3 cycles earlier");
    end

  a_nar_qualified: assert property (@(posedge clk_i) disable iff (reset_i)
    nar_o |-> valid_o)
    else begin
      failures++;
      $error("nar_o high without valid_o");
    end

endmodule

bind ppu_vec_top ppu_vec_properties props0 (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .valid_i (valid_i),
  .valid_o (valid_o),
  .nar_o   (nar_o)
);

// File: tb/tb_ppu_vec.sv
`timescale 1ns/1ns
`include "ppu_defines.svh"

module tb_ppu_vec
  import ppu_pkg::*;
();

  localparam int LANES = `PPU_LANES;
  localparam int WAIT_LIMIT = 20;

  logic       clk;
  logic       reset;
  logic       cmd_valid;
  ppu_op_e    cmd_op;
  posit_vec_t cmd_a;
  posit_vec_t cmd_b;
  posit_vec_t result;
  logic       result_valid;
  logic       result_nar;

  int cycle_cnt;
  int value_errors;
  int timing_errors;
  int timeouts;
  int vectors_checked;

  // expected vectors in issue order, with the cycle each one is due.
  posit_vec_t exp_res[$];
  logic       exp_nar[$];
  int         exp_cyc[$];

  ppu_clock_gen #(.PERIOD(8)) clock0 (.clk_o(clk));

  ppu_vec_top dut0 (
    .clk_i    (clk),
    .reset_i  (reset),
    .valid_i  (cmd_valid),
    .op_i     (cmd_op),
    .a_i      (cmd_a),
    .b_i      (cmd_b),
    .result_o (result),
    .valid_o  (result_valid),
    .nar_o    (result_nar)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // every 8-bit posit with no exponent field is a whole multiple of 2^-6.
  function automatic longint posit_units(input posit_t p);
    posit_t mag;
    int     run;
    int     k;
    int     fb;
    longint frac;
    mag = p[7] ? -p : p;
    run = 1;
    while (run < 7 && mag[6 - run] == mag[6]) begin
      run++;
    end
    k = mag[6] ? run - 1 : -run;
    fb = (run < 6) ? 6 - run : 0;
    frac = longint'(mag) & ((longint'(1) << fb) - 1);
    return ((longint'(1) << fb) + frac) << (k + 6 - fb);
  endfunction

  // nearest posit to x, given in units of 2^-12, ties to the even code.
  function automatic posit_t encode_units(input logic neg, input longint x);
    int     lo;
    int     pick;
    longint p_lo;
    longint p_hi;
    lo = 1;
    while (lo < 127 && posit_units(posit_t'(lo + 1)) * 64 <= x) begin
      lo++;
    end
    p_lo = posit_units(posit_t'(lo)) * 64;
    pick = lo;
    // below minpos stays at minpos, above maxpos stays at maxpos.
    if (lo < 127 && p_lo <= x) begin
      p_hi = posit_units(posit_t'(lo + 1)) * 64;
      if ((2 * x > p_lo + p_hi) || (2 * x == p_lo + p_hi && lo % 2 == 1)) begin
        pick = lo + 1;
      end
    end
    return neg ? posit_t'(-pick) : posit_t'(pick);
  endfunction

  function automatic posit_t model_mul(input posit_t a, input posit_t b);
    if (a == 8'h80 || b == 8'h80) begin
      return 8'h80;
    end
    if (a == 8'h00 || b == 8'h00) begin
      return 8'h00;
    end
    return encode_units(a[7] ^ b[7], posit_units(a) * posit_units(b));
  endfunction

  // compares the vector on the outputs with the oldest one still expected.
  task automatic check_vector();
    posit_vec_t exp_vec;
    logic       nar;
    int         due;
    if (exp_res.size() == 0) begin
      $display("valid_o came with no command outstanding");
      timing_errors++;
    end else begin
      exp_vec = exp_res.pop_front();
      nar = exp_nar.pop_front();
      due = exp_cyc.pop_front();
      if (cycle_cnt != due) begin
        $display("valid_o came at cycle %0d but was due at cycle %0d", cycle_cnt, due);
        timing_errors++;
      end
      for (int i = 0; i < LANES; i++) begin
        if (result[i] !== exp_vec[i]) begin
          $display("ERROR result_o[%0d] expected 0x%02h actual 0x%02h",
                   i, exp_vec[i], result[i]);
          value_errors++;
        end
      end
      if (result_nar !== nar) begin
        $display("ERROR nar_o expected 0x%0h actual 0x%0h", nar, result_nar);
        value_errors++;
      end
      vectors_checked++;
    end
  endtask

  task automatic issue_cmd(input ppu_op_e op, input posit_vec_t a, input posit_vec_t b);
    posit_vec_t exp_vec;
    logic       nar;
    nar = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      exp_vec[i] = model_mul(a[i], (op == OP_SQR) ? a[i] : b[i]);
      nar = nar | (exp_vec[i] == 8'h80);
    end
    @(negedge clk);
    // an earlier command of a back-to-back burst may be due on this cycle.
    if (result_valid === 1'b1) begin
      check_vector();
    end
    cmd_valid = 1'b1;
    cmd_op = op;
    cmd_a = a;
    cmd_b = b;
    exp_res.push_back(exp_vec);
    exp_nar.push_back(nar);
    exp_cyc.push_back(cycle_cnt + 3);
  endtask

  // checks every outstanding vector in order, on the cycle it is due.
  task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_res.size() > 0 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      cmd_valid = 1'b0;
      waited++;
      if (result_valid === 1'b1) begin
        check_vector();
        waited = 0;
      end
    end
    if (exp_res.size() > 0) begin
      $display("timeout, valid_o did not come within %0d cycles", WAIT_LIMIT);
      timeouts++;
      exp_res.delete();
      exp_nar.delete();
      exp_cyc.delete();
    end
  endtask

  task automatic test_idle_after_reset();
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      if (result_valid !== 1'b0) begin
        $display("ERROR valid_o expected 0x0 actual 0x%0h", result_valid);
        value_errors++;
      end
      if (result_nar !== 1'b0) begin
        $display("ERROR nar_o expected 0x0 actual 0x%0h", result_nar);
        value_errors++;
      end
    end
  endtask

  // lanes 0 to 3 hold 1 x 1.8125, 2 x 2, -1 x -1 and 0.5 x 4.
  task automatic test_exact_mul();
    issue_cmd(OP_MUL, {8'h20, 8'hC0, 8'h60, 8'h40}, {8'h70, 8'hC0, 8'h60, 8'h5A});
    drain_results();
  endtask

  task automatic test_special_values();
    issue_cmd(OP_MUL, {8'h40, 8'h33, 8'h80, 8'h00}, {8'h40, 8'h80, 8'h40, 8'h55});
    drain_results();
    // maxpos and minpos squared saturate and no lane is NaR.
    issue_cmd(OP_MUL, {8'hC0, 8'h01, 8'h7F, 8'h00}, {8'h40, 8'h01, 8'h7F, 8'h30});
    drain_results();
  endtask

  task automatic test_square();
    for (int i = 0; i < 12; i++) begin
      issue_cmd(OP_SQR, $urandom, $urandom);
      drain_results();
    end
  endtask

  task automatic test_random_ops();
    for (int i = 0; i < 60; i++) begin
      issue_cmd(ppu_op_e'($urandom_range(1, 0)), $urandom, $urandom);
      drain_results();
    end
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 6; i++) begin
      issue_cmd(ppu_op_e'($urandom_range(1, 0)), $urandom, $urandom);
    end
    drain_results();
  endtask

  initial begin
    void'($urandom(4253));
    cmd_valid = 1'b0;
    cmd_op = OP_MUL;
    cmd_a = '0;
    cmd_b = '0;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_idle_after_reset();
    test_exact_mul();
    test_special_values();
    test_square();
    test_random_ops();
    test_back_to_back();
    $display("errors value %0d, timing %0d, timeout %0d, assertion %0d, vectors checked %0d",
             value_errors, timing_errors, timeouts, dut0.props0.failures, vectors_checked);
    if (value_errors + timing_errors + timeouts + dut0.props0.failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: ppu_vec

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ppu_pkg.sv
      - hdl/posit_decode.sv
      - hdl/fir_mul.sv
      - hdl/fir_to_posit.sv
      - hdl/ppu_lane.sv
      - hdl/op_dispatch.sv
      - hdl/result_collect.sv
      - hdl/ppu_vec_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/ppu_clock_gen.sv
      - tb/ppu_vec_properties.sv
      - tb/tb_ppu_vec.sv

// File: filelist.f
+incdir+hdl
hdl/ppu_pkg.sv
hdl/posit_decode.sv
hdl/fir_mul.sv
hdl/fir_to_posit.sv
hdl/ppu_lane.sv
hdl/op_dispatch.sv
hdl/result_collect.sv
hdl/ppu_vec_top.sv
tb/ppu_clock_gen.sv
tb/ppu_vec_properties.sv
tb/tb_ppu_vec.sv
